// ==== compile.f ====
verilog/desc_pkg.sv
verilog/xfer_pkg.sv
verilog/dma_ifs.sv
verilog/cpu_port.sv
verilog/desc_table_arb.sv
verilog/block_scheduler.sv
verilog/block_executor.sv
verilog/dma_sched_top.sv
dv/tb_dma_sched_chk.sv
dv/tb_dma_sched.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f compile.f --top-module tb_dma_sched -o tb_dma_sched \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_dma_sched > sim.log 2>&1 || echo "simulator exited with an error"
grep -qx "ALL TESTS PASSED" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// ==== dv/tb_dma_sched.sv ====
`timescale 1ns/1ps

module tb_dma_sched
  import desc_pkg::*;
  import xfer_pkg::*;
();

  localparam int CLK_PERIOD = 100;
  localparam int T1_CYCLES = 300;    // cycle budgets per test
  localparam int T2_CYCLES = 2500;
  localparam int T3_CYCLES = 3500;
  localparam int T4_CYCLES = 2500;
  localparam int T5_CYCLES = 11200;
  localparam int BUDGET = T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES + T5_CYCLES;

  logic        CLK;
  logic        RST;
  logic        cpu_rd;
  logic        cpu_wr;
  slot_t       cpu_addr;
  desc_t       cpu_wdata;
  logic        cpu_ack;
  desc_t       cpu_rdata;
  logic        mv_valid;
  addr_t       mv_addr;
  words_t      mv_words;
  slot_t       mv_slot;
  logic        mv_ready;
  logic        irq;
  slot_t       irq_slot;
  int          stall_mode;  // 0 ready, 1 random, 2 held off
  int          err_value;
  int          err_other;
  logic [41:0] exp_q [NUM_SLOTS][$];  // {slot, words, addr}
  logic [41:0] mv_exp;
  slot_t       mon_slot;
  slot_t       irq_hist [$];

  dma_sched_top u_dut (
    .CLK(CLK), .RST(RST), .cpu_rd(cpu_rd), .cpu_wr(cpu_wr), .cpu_addr(cpu_addr),
    .cpu_wdata(cpu_wdata), .cpu_ack(cpu_ack), .cpu_rdata(cpu_rdata), .mv_valid(mv_valid),
    .mv_addr(mv_addr), .mv_words(mv_words), .mv_slot(mv_slot), .mv_ready(mv_ready),
    .irq(irq), .irq_slot(irq_slot)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  always @(negedge CLK)
    case (stall_mode)
      0: mv_ready = 1'b1;
      1: mv_ready = ($urandom % 3) != 0;
      default: mv_ready = 1'b0;
    endcase

  // --------------------------------------------------------------------------
  // compare tasks
  // --------------------------------------------------------------------------
  task automatic check_desc(input string name, input desc_t exp, input desc_t got);
    if (got !== exp)
    begin
      err_value++;
      $display("** Error: %s expected 0x%h, got 0x%h", name, exp, got);
    end
  endtask

  task automatic check_burst(input addr_t ea, input words_t ew, input slot_t es,
                             input addr_t ga, input words_t gw, input slot_t gs);
    if (ga !== ea)
    begin
      err_value++;
      $display("** Error: mv_addr expected 0x%h, got 0x%h", ea, ga);
    end
    if (gw !== ew)
    begin
      err_value++;
      $display("** Error: mv_words expected 0x%h, got 0x%h", ew, gw);
    end
    if (gs !== es)
    begin
      err_value++;
      $display("** Error: mv_slot expected 0x%h, got 0x%h", es, gs);
    end
  endtask

  task automatic check_irq(input slot_t exp, input slot_t got);
    if (got !== exp)
    begin
      err_value++;
      $display("** Error: irq_slot expected 0x%h, got 0x%h", exp, got);
    end
  endtask

  // --------------------------------------------------------------------------
  // reference model and monitors
  // --------------------------------------------------------------------------
  function automatic desc_t make_desc(input logic act, input logic ien, input int words,
                                      input addr_t a);
    desc_t d;
    d = '0;
    d[ACTIVE_BIT] = act;
    d[IRQ_EN_BIT] = ien;
    d[LEN_HI:LEN_LO] = len_t'(words);
    d[ADDR_HI:0] = a;
    return d;
  endfunction

  // raw cpu word, junk in the reserved bits
  function automatic desc_t cpu_word(input logic act, input logic ien, input int bytes,
                                     input addr_t a);
    return {act, ien, 6'h3f, 24'(bytes), a};
  endfunction

  task automatic add_model(input slot_t s, input int words, input addr_t a);
    int    blk;
    int    room;
    int    rem;
    addr_t cur;
    cur = a;
    rem = words;
    while (rem > 0)
    begin
      blk = (rem > MAX_BLOCK_WORDS) ? MAX_BLOCK_WORDS : rem;
      room = (PAGE_BYTES - int'(cur & addr_t'(PAGE_BYTES - 1))) / 4;
      if (blk <= room)
        exp_q[s].push_back({s, words_t'(blk), cur});
      else
      begin
        exp_q[s].push_back({s, words_t'(room), cur});
        exp_q[s].push_back({s, words_t'(blk - room), cur + addr_t'(room * 4)});
      end
      cur = cur + addr_t'(blk * 4);
      rem = rem - blk;
    end
  endtask

  // model slot whose next burst starts at this address
  function automatic slot_t owner_slot(input addr_t a, input slot_t dflt);
    slot_t hit;
    hit = dflt;
    for (int s = 0; s < NUM_SLOTS; s++)
      if (exp_q[s].size() != 0 && exp_q[s][0][31:0] == a)
        hit = slot_t'(s);
    return hit;
  endfunction

  always @(posedge CLK)
    if (RST && mv_valid && mv_ready)
    begin
      mon_slot = owner_slot(mv_addr, mv_slot);
      if (exp_q[mon_slot].size() == 0)
      begin
        err_other++;
        $display("unexpected burst on slot %0d at 0x%h", mv_slot, mv_addr);
      end
      else
      begin
        mv_exp = exp_q[mon_slot].pop_front();
        check_burst(mv_exp[31:0], mv_exp[38:32], mv_exp[41:39], mv_addr, mv_words, mv_slot);
      end
    end

  always @(posedge CLK)
    if (RST && irq)
      irq_hist.push_back(irq_slot);

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------
  task automatic cpu_access(input logic write, input slot_t s, input desc_t wd,
                            output desc_t rd_data);
    int n;
    n = 0;
    cpu_wr = write;
    cpu_rd = !write;
    cpu_addr = s;
    cpu_wdata = wd;
    @(negedge CLK);
    while (!cpu_ack && n < 200)
    begin
      @(negedge CLK);
      n++;
    end
    if (!cpu_ack)
    begin
      err_other++;
      $display("cpu access to slot %0d was never acknowledged", s);
    end
    rd_data = cpu_rdata;
    cpu_wr = 1'b0;
    cpu_rd = 1'b0;
  endtask

  function automatic int pending();
    int total;
    total = 0;
    for (int s = 0; s < NUM_SLOTS; s++)
      total += exp_q[s].size();
    return total;
  endfunction

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (pending() != 0 && n < limit)
    begin
      @(negedge CLK);
      n++;
    end
    for (int s = 0; s < NUM_SLOTS; s++)
      if (exp_q[s].size() != 0)
      begin
        err_other++;
        $display("%0d burst(s) for slot %0d never arrived", exp_q[s].size(), s);
        exp_q[s].delete();
      end
    repeat (40) @(negedge CLK);  // catch stray bursts
  endtask

  task automatic wait_irq(input slot_t s, input int limit);
    int n;
    n = 0;
    while (irq_hist.size() == 0 && n < limit)
    begin
      @(negedge CLK);
      n++;
    end
    if (irq_hist.size() == 0)
    begin
      err_other++;
      $display("no irq arrived from slot %0d", s);
    end
    else
      check_irq(s, irq_hist.pop_front());
  endtask

  task automatic expect_no_irq();
    while (irq_hist.size() != 0)
    begin
      err_other++;
      $display("unexpected irq from slot %0d", irq_hist.pop_front());
    end
  endtask

  // --------------------------------------------------------------------------
  // tests
  // --------------------------------------------------------------------------
  task automatic test_normalize();
    desc_t got;
    cpu_access(1'b1, 3'd0, cpu_word(1'b0, 1'b1, 101, 32'h0000_1237), got);
    cpu_access(1'b0, 3'd0, '0, got);
    check_desc("cpu_rdata", make_desc(1'b0, 1'b1, 26, 32'h0000_1234), got);
  endtask

  task automatic test_short_irq();
    desc_t got;
    add_model(3'd1, 25, 32'h0000_2000);
    cpu_access(1'b1, 3'd1, cpu_word(1'b1, 1'b1, 100, 32'h0000_2000), got);
    wait_irq(3'd1, 2000);
    wait_drain(2000);
    expect_no_irq();
    cpu_access(1'b0, 3'd1, '0, got);
    check_desc("cpu_rdata", make_desc(1'b0, 1'b1, 0, 32'h0000_2000 + 100), got);
  endtask

  task automatic test_long();
    desc_t got;
    add_model(3'd2, 300, 32'h0000_4000);
    cpu_access(1'b1, 3'd2, cpu_word(1'b1, 1'b0, 1200, 32'h0000_4000), got);
    wait_drain(3000);
    expect_no_irq();
    cpu_access(1'b0, 3'd2, '0, got);
    check_desc("cpu_rdata", make_desc(1'b0, 1'b0, 0, 32'h0000_4000 + 1200), got);
  endtask

  task automatic test_page_split();
    desc_t got;
    add_model(3'd3, 64, 32'h0000_0ff0);
    cpu_access(1'b1, 3'd3, cpu_word(1'b1, 1'b0, 256, 32'h0000_0ff0), got);
    wait_drain(2000);
    expect_no_irq();
  endtask

  task automatic test_stall();
    desc_t got;
    stall_mode <= 2;  // mover off, queue and credits fill up
    add_model(3'd4, 200, 32'h0000_7f80);
    add_model(3'd5, 130, 32'h0000_9000);
    add_model(3'd6, 70, 32'h0000_afc0);
    cpu_access(1'b1, 3'd4, cpu_word(1'b1, 1'b0, 800, 32'h0000_7f80), got);
    cpu_access(1'b1, 3'd5, cpu_word(1'b1, 1'b0, 520, 32'h0000_9000), got);
    cpu_access(1'b1, 3'd6, cpu_word(1'b1, 1'b0, 280, 32'h0000_afc0), got);
    for (int i = 0; i < 6; i++)
    begin
      if (i == 3)
        stall_mode <= 1;
      cpu_access(1'b0, 3'd0, '0, got);
      check_desc("cpu_rdata", make_desc(1'b0, 1'b1, 26, 32'h0000_1234), got);
      cpu_access(1'b0, 3'd7, '0, got);
      check_desc("cpu_rdata", '0, got);
      repeat (20) @(negedge CLK);
    end
    wait_drain(9000);
    stall_mode <= 0;
    expect_no_irq();
  endtask

  initial
  begin
    void'($urandom(32'h70b));
    CLK = 1'b0;
    RST = 1'b0;
    cpu_rd = 1'b0;
    cpu_wr = 1'b0;
    cpu_addr = '0;
    cpu_wdata = '0;
    mv_ready = 1'b0;
    stall_mode <= 0;
    err_value = 0;
    err_other = 0;
    repeat (10) @(negedge CLK);
    RST = 1'b1;
    repeat (2) @(negedge CLK);
    test_normalize();
    test_short_irq();
    test_long();
    test_page_split();
    test_stall();
    $display("errors: %0d value mismatches, %0d missing or unexpected events",
             err_value, err_other);
    if (err_value + err_other == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  initial
  begin
    #(BUDGET * CLK_PERIOD);
    $display("watchdog timeout after %0d cycles", BUDGET);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== dv/tb_dma_sched_chk.sv ====
`timescale 1ns/1ps

module tb_dma_sched_chk
  import desc_pkg::*;
  import xfer_pkg::*;
(
  input logic   CLK,
  input logic   RST,
  input logic   cpu_ack,
  input logic   irq,
  input logic   mv_valid,
  input logic   mv_ready,
  input addr_t  mv_addr,
  input words_t mv_words,
  input slot_t  mv_slot
);

  mover_hold: assert property (@(posedge CLK) disable iff (!RST)
    mv_valid && !mv_ready |=> mv_valid && $stable(mv_addr) && $stable(mv_words) && $stable(mv_slot))
    else $error("mover burst changed while stalled");

  words_range: assert property (@(posedge CLK) disable iff (!RST)
    mv_valid |-> mv_words >= words_t'(1) && mv_words <= words_t'(MAX_BLOCK_WORDS))
    else $error("burst length %0d out of range", mv_words);

  // burst must end at or before the next page boundary
  page_bound: assert property (@(posedge CLK) disable iff (!RST)
    mv_valid |-> int'(mv_addr & addr_t'(PAGE_BYTES - 1)) + 4 * int'(mv_words) <= PAGE_BYTES)
    else $error("burst at 0x%h crosses a page", mv_addr);

  ack_pulse: assert property (@(posedge CLK) disable iff (!RST) cpu_ack |=> !cpu_ack)
    else $error("cpu_ack longer than one cycle");

  irq_pulse: assert property (@(posedge CLK) disable iff (!RST) irq |=> !irq)
    else $error("irq longer than one cycle");

endmodule

bind dma_sched_top tb_dma_sched_chk u_chk (
  .CLK(CLK), .RST(RST), .cpu_ack(cpu_ack), .irq(irq), .mv_valid(mv_valid),
  .mv_ready(mv_ready), .mv_addr(mv_addr), .mv_words(mv_words), .mv_slot(mv_slot)
);

// ==== verilog/dma_sched_top.sv ====
`timescale 1ns/1ps

module dma_sched_top (
  input  logic        CLK,
  input  logic        RST,
  input  logic        cpu_rd,
  input  logic        cpu_wr,
  input  logic [2:0]  cpu_addr,
  input  logic [63:0] cpu_wdata,
  output logic        cpu_ack,
  output logic [63:0] cpu_rdata,
  output logic        mv_valid,
  output logic [31:0] mv_addr,
  output logic [6:0]  mv_words,
  output logic [2:0]  mv_slot,
  input  logic        mv_ready,
  output logic        irq,
  output logic [2:0]  irq_slot
);

  table_port_if cpu_tbl ();
  table_port_if sched_tbl ();
  blk_cmd_if    blk_cmd ();

  cpu_port u_cpu_port (
    .CLK(CLK), .RST(RST), .rd(cpu_rd), .wr(cpu_wr), .addr(cpu_addr),
    .wdata(cpu_wdata), .ack(cpu_ack), .rdata(cpu_rdata), .tbl(cpu_tbl)
  );

  desc_table_arb u_table (.CLK(CLK), .RST(RST), .cpu(cpu_tbl), .sched(sched_tbl));

  block_scheduler u_sched (
    .CLK(CLK), .RST(RST), .tbl(sched_tbl), .cmd(blk_cmd), .irq(irq), .irq_slot(irq_slot)
  );

  block_executor u_exec (
    .CLK(CLK), .RST(RST), .cmd(blk_cmd), .mv_valid(mv_valid), .mv_addr(mv_addr),
    .mv_words(mv_words), .mv_slot(mv_slot), .mv_ready(mv_ready)
  );

endmodule

// ==== verilog/block_executor.sv ====
`timescale 1ns/1ps

module block_executor
  import desc_pkg::*;
  import xfer_pkg::*;
(
  input  logic     CLK,
  input  logic     RST,
  blk_cmd_if.sink  cmd,
  output logic     mv_valid,
  output addr_t    mv_addr,
  output words_t   mv_words,
  output slot_t    mv_slot,
  input  logic     mv_ready
);

  typedef logic [$clog2(CMD_CREDITS)-1:0]   qptr_t;
  typedef logic [$clog2(CMD_CREDITS+1)-1:0] qcnt_t;

  addr_t  q_addr [CMD_CREDITS];
  words_t q_words [CMD_CREDITS];
  slot_t  q_slot [CMD_CREDITS];
  qptr_t  wr_ptr;
  qptr_t  rd_ptr;
  qcnt_t  count;
  logic   second;  // remainder burst after a page split
  logic   fits;
  logic   accept;
  logic   last_acc;
  addr_t  page_off;
  addr_t  room_bytes;
  words_t first_words;

  // ------------------------------------------------------------------------
  // page split of the head block
  // ------------------------------------------------------------------------
  assign page_off = q_addr[rd_ptr] & addr_t'(PAGE_BYTES - 1);
  assign room_bytes = addr_t'(PAGE_BYTES) - page_off;
  assign fits = addr_t'(q_words[rd_ptr]) <= (room_bytes >> 2);
  assign first_words = fits ? q_words[rd_ptr] : words_t'(room_bytes >> 2);

  assign mv_valid = (count != '0);
  assign mv_addr = second ? q_addr[rd_ptr] + room_bytes : q_addr[rd_ptr];
  assign mv_words = second ? q_words[rd_ptr] - first_words : first_words;
  assign mv_slot = q_slot[rd_ptr];

  assign accept = mv_valid && mv_ready;
  assign last_acc = accept && (second || fits);
  assign cmd.credit_ret = last_acc;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      second <= 1'b0;
    end
    else
    begin
      if (cmd.valid)
        wr_ptr <= (wr_ptr == qptr_t'(CMD_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
      if (last_acc)
        rd_ptr <= (rd_ptr == qptr_t'(CMD_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + qcnt_t'(cmd.valid) - qcnt_t'(last_acc);
      if (accept)
        second <= !second && !fits;
    end
  end

  // never full, the credits see to that
  always_ff @(posedge CLK)
  begin
    if (cmd.valid)
    begin
      q_addr[wr_ptr] <= cmd.addr;
      q_words[wr_ptr] <= cmd.words;
      q_slot[wr_ptr] <= cmd.slot;
    end
  end

endmodule

// ==== verilog/block_scheduler.sv ====
`timescale 1ns/1ps

module block_scheduler
  import desc_pkg::*;
  import xfer_pkg::*;
(
  input  logic            CLK,
  input  logic            RST,
  table_port_if.requester tbl,
  blk_cmd_if.source       cmd,
  output logic            irq,
  output slot_t           irq_slot
);

  typedef enum logic [2:0] {S_IDLE, S_READ, S_WAIT, S_EVAL, S_WRITE} state_t;
  typedef logic [$clog2(CMD_CREDITS+1)-1:0] credit_t;

  state_t  state;
  slot_t   slot_ptr;
  credit_t credits;
  logic    irq_pend;
  desc_t   desc_r;
  desc_t   wb_desc;
  len_t    rem_len;
  len_t    next_len;
  words_t  blk_words;
  addr_t   next_addr;

  assign tbl.req = (state == S_READ) || (state == S_WRITE);
  assign tbl.we = (state == S_WRITE);
  assign tbl.addr = slot_ptr;

  // ------------------------------------------------------------------------
  // block cut and descriptor update
  // ------------------------------------------------------------------------
  assign rem_len = desc_r[LEN_HI:LEN_LO];
  assign blk_words = (rem_len > len_t'(MAX_BLOCK_WORDS)) ? words_t'(MAX_BLOCK_WORDS)
                                                         : words_t'(rem_len);
  assign next_len = rem_len - len_t'(blk_words);
  assign next_addr = desc_r[ADDR_HI:0] + addr_t'({blk_words, 2'b00});

  always_comb
  begin
    wb_desc = desc_r;
    wb_desc[ACTIVE_BIT] = (next_len != '0);
    wb_desc[LEN_HI:LEN_LO] = next_len;
    wb_desc[ADDR_HI:0] = next_addr;
  end

  // ------------------------------------------------------------------------
  // slot walk
  // ------------------------------------------------------------------------
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state <= S_IDLE;
      slot_ptr <= '0;
      credits <= credit_t'(CMD_CREDITS);
      cmd.valid <= 1'b0;
      irq_pend <= 1'b0;
      irq <= 1'b0;
      irq_slot <= '0;
    end
    else
    begin
      cmd.valid <= 1'b0;
      irq <= 1'b0;
      case (state)
        S_IDLE:
          if (credits != '0)  // no credit, no read
            state <= S_READ;
        S_READ:
          if (tbl.gnt)
            state <= S_WAIT;
        S_WAIT:
          state <= S_EVAL;
        S_EVAL:
          if (desc_r[ACTIVE_BIT])
          begin
            cmd.valid <= (rem_len != '0);
            irq_pend <= desc_r[IRQ_EN_BIT] && (next_len == '0);
            state <= S_WRITE;
          end
          else
          begin
            slot_ptr <= slot_ptr + 1'b1;
            state <= S_IDLE;
          end
        S_WRITE:
          if (tbl.gnt)
          begin
            irq <= irq_pend;
            irq_slot <= slot_ptr;
            slot_ptr <= slot_ptr + 1'b1;
            state <= S_IDLE;
          end
        default:
          state <= S_IDLE;
      endcase

      case ({cmd.valid, cmd.credit_ret})
        2'b10: credits <= credits - 1'b1;
        2'b01: credits <= credits + 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge CLK)
  begin
    if (state == S_WAIT)
      desc_r <= tbl.rdata;
    if (state == S_EVAL)
    begin
      tbl.wdata <= wb_desc;
      cmd.addr <= desc_r[ADDR_HI:0];
      cmd.words <= blk_words;
      cmd.slot <= slot_ptr;
    end
  end

endmodule

// ==== verilog/desc_table_arb.sv ====
`timescale 1ns/1ps

module desc_table_arb
  import desc_pkg::*;
(
  input  logic          CLK,
  input  logic          RST,
  table_port_if.arbiter cpu,
  table_port_if.arbiter sched
);

  desc_t mem [NUM_SLOTS];
  logic  last_cpu;  // cpu got the previous grant
  logic  cpu_win;

  // round robin, the port not granted last time wins a tie
  assign cpu_win = cpu.req && (!sched.req || !last_cpu);
  assign cpu.gnt = cpu_win;
  assign sched.gnt = sched.req && !cpu_win;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      for (int i = 0; i < NUM_SLOTS; i++)
        mem[i] <= '0;
      last_cpu <= 1'b0;
    end
    else
    begin
      if (cpu.gnt)
        last_cpu <= 1'b1;
      else if (sched.gnt)
        last_cpu <= 1'b0;

      if (cpu.gnt && cpu.we)
        mem[cpu.addr] <= cpu.wdata;
      if (sched.gnt && sched.we)
        mem[sched.addr] <= sched.wdata;
    end
  end

  // read data holds until the next read grant on the same port
  always_ff @(posedge CLK)
  begin
    if (cpu.gnt && !cpu.we)
      cpu.rdata <= mem[cpu.addr];
    if (sched.gnt && !sched.we)
      sched.rdata <= mem[sched.addr];
  end

endmodule

// ==== verilog/cpu_port.sv ====
`timescale 1ns/1ps

module cpu_port
  import desc_pkg::*;
(
  input  logic            CLK,
  input  logic            RST,
  input  logic            rd,
  input  logic            wr,
  input  slot_t           addr,
  input  desc_t           wdata,
  output logic            ack,
  output desc_t           rdata,
  table_port_if.requester tbl
);

  logic                 busy;
  logic                 rd_wait;
  logic [CPU_LEN_W-1:0] cpu_len;
  len_t                 cpu_words;
  desc_t                norm;

  assign cpu_len = wdata[CPU_LEN_HI:CPU_LEN_LO];
  assign cpu_words = cpu_len[CPU_LEN_W-1:2] + len_t'(|cpu_len[1:0]);  // round up

  always_comb
  begin
    norm = '0;
    norm[ACTIVE_BIT] = wdata[ACTIVE_BIT];
    norm[IRQ_EN_BIT] = wdata[IRQ_EN_BIT];
    norm[LEN_HI:LEN_LO] = cpu_words;
    norm[ADDR_HI:0] = {wdata[ADDR_HI:2], 2'b00};  // word aligned
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      tbl.req <= 1'b0;
      busy <= 1'b0;
      rd_wait <= 1'b0;
      ack <= 1'b0;
    end
    else
    begin
      ack <= rd_wait;
      rd_wait <= 1'b0;
      if (!busy && (rd || wr))
      begin
        tbl.req <= 1'b1;
        busy <= 1'b1;
      end
      else if (tbl.gnt)
      begin
        tbl.req <= 1'b0;
        ack <= tbl.we;       // writes ack right away
        rd_wait <= !tbl.we;  // reads wait for rdata
      end
      if (ack)
        busy <= 1'b0;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (!busy)
    begin
      tbl.we <= wr;
      tbl.addr <= addr;
      tbl.wdata <= norm;
    end
    if (rd_wait)
      rdata <= tbl.rdata;
  end

endmodule

// ==== verilog/dma_ifs.sv ====
`timescale 1ns/1ps

// one access port into the descriptor table
interface table_port_if
  import desc_pkg::*;
();
  logic  req;
  logic  we;
  slot_t addr;
  desc_t wdata;
  logic  gnt;    // single cycle, combinational from req
  desc_t rdata;  // valid the cycle after gnt

  modport requester (output req, we, addr, wdata, input gnt, rdata);
  modport arbiter (input req, we, addr, wdata, output gnt, rdata);
endinterface

// block hand-off from scheduler to executor, credit based
interface blk_cmd_if
  import desc_pkg::*;
  import xfer_pkg::*;
();
  logic   valid;
  addr_t  addr;
  words_t words;
  slot_t  slot;
  logic   credit_ret;

  modport source (output valid, addr, words, slot, input credit_ret);
  modport sink (input valid, addr, words, slot, output credit_ret);
endinterface

// ==== verilog/xfer_pkg.sv ====
package xfer_pkg;

  // ------------------------------------------------------------------------
  // blocks and bursts
  // ------------------------------------------------------------------------
  typedef logic [6:0] words_t;  // 1..64 words per block or burst

  localparam int MAX_BLOCK_WORDS = 64;

  // bursts never cross this boundary
  localparam int PAGE_BYTES = 4096;

  // executor queue depth, also the scheduler's starting credits
  localparam int CMD_CREDITS = 2;

endpackage

// ==== verilog/desc_pkg.sv ====
package desc_pkg;

  // ------------------------------------------------------------------------
  // descriptor table
  // ------------------------------------------------------------------------
  localparam int NUM_SLOTS = 8;

  typedef logic [2:0]  slot_t;
  typedef logic [63:0] desc_t;
  typedef logic [21:0] len_t;   // remaining length in words
  typedef logic [31:0] addr_t;  // byte address

  // stored descriptor layout, other bits read as zero
  localparam int ACTIVE_BIT = 63;
  localparam int IRQ_EN_BIT = 62;
  localparam int LEN_HI     = 55;
  localparam int LEN_LO     = 34;
  localparam int ADDR_HI    = 31;

  // byte length as written by the cpu
  localparam int CPU_LEN_HI = 55;
  localparam int CPU_LEN_LO = 32;
  localparam int CPU_LEN_W  = 24;

endpackage
